// File: verilog/sys_master_params.svh
`ifndef SYS_MASTER_PARAMS_SVH
`define SYS_MASTER_PARAMS_SVH

// host word and AXI4-Lite beat widths
`define HOST_DATA_W 64
`define AXI_DATA_W  32
`define AXI_ADDR_W  32

// sys_clock_i cycles of held system reset once rst_i drops
`define RESET_HOLD_CYCLES 16

// AXI response codes
// the numeric order gives the merge priority of two beats
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10
`define RESP_DECERR 2'b11

`endif

// File: verilog/sys_master_pkg.sv
package sys_master_pkg;

`include "sys_master_params.svh"

    // byte address on the AXI side
    typedef logic [`AXI_ADDR_W-1:0] addr_t;

    // full host word, split into two beats
    typedef logic [`HOST_DATA_W-1:0] host_data_t;

    // one AXI4-Lite beat
    typedef logic [`AXI_DATA_W-1:0] axi_data_t;

    // byte strobes
    typedef logic [`HOST_DATA_W/8-1:0] host_strb_t;
    typedef logic [`AXI_DATA_W/8-1:0]  axi_strb_t;

    typedef logic [1:0] resp_t;  // bresp / rresp

    // W channel payload
    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
    } wbeat_t;

endpackage : sys_master_pkg

// File: verilog/beat_if.sv
interface beat_if
    import sys_master_pkg::*;
();

    // request side, start is a single cycle pulse
    logic      start;
    logic      is_write;
    addr_t     addr;
    wbeat_t    wbeat;

    // result side, valid only while done is high
    logic      done;
    axi_data_t rdata;
    resp_t     resp;

    // sequencer kicks off beats and waits for done
    modport ctrl (
        output start,
        input  done
    );

    // word buffer supplies the beat payload and merges the result
    modport data (
        output is_write, addr, wbeat,
        input  done, rdata, resp
    );

    modport engine (
        input  start, is_write, addr, wbeat,
        output done, rdata, resp
    );

endinterface : beat_if

// File: verilog/reset_hold_timer.sv
`include "sys_master_params.svh"

module reset_hold_timer (
    input  logic sys_clock_i,
    input  logic rst_i,
    output logic sys_resetn_o
);

    localparam int CNT_W = $clog2(`RESET_HOLD_CYCLES + 1);

    logic [CNT_W-1:0] cnt_q;

    // reload while rst_i is high, count down afterwards
    // release lands on the edge where the count hits zero
    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            cnt_q        <= CNT_W'(`RESET_HOLD_CYCLES);
            sys_resetn_o <= 1'b0;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
            if (cnt_q == CNT_W'(1)) begin
                sys_resetn_o <= 1'b1;  // last step of the hold
            end
        end
    end

endmodule : reset_hold_timer

// File: verilog/host_cmd_fsm.sv
module host_cmd_fsm (
    input  logic sys_clock_i,
    input  logic rst_i,
    input  logic sys_resetn_i,  // system out of reset
    input  logic host_req_i,
    output logic host_ack_o,
    output logic load_o,        // capture the host command
    output logic hi_sel_o,      // high half of the word on the beat
    beat_if.ctrl beat
);

    typedef enum logic [2:0] {
        IDLE,
        LOW_BEAT,
        HIGH_BEAT,
        ACK,
        RELEASE
    } state_t;

    state_t state_q;
    logic   start_q;

    // command is latched on the edge that leaves IDLE
    assign load_o     = (state_q == IDLE) && sys_resetn_i && host_req_i;
    assign beat.start = start_q;

    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            state_q    <= IDLE;
            start_q    <= 1'b0;
            hi_sel_o   <= 1'b0;
            host_ack_o <= 1'b0;
        end else begin
            start_q <= 1'b0;  // pulse only
            case (state_q)
                IDLE: begin
                    if (load_o) begin
                        state_q  <= LOW_BEAT;
                        start_q  <= 1'b1;
                        hi_sel_o <= 1'b0;
                    end
                end
                LOW_BEAT: begin
                    // low word finished, switch halves and go again
                    if (beat.done) begin
                        state_q  <= HIGH_BEAT;
                        start_q  <= 1'b1;
                        hi_sel_o <= 1'b1;
                    end
                end
                HIGH_BEAT: begin
                    if (beat.done) begin
                        state_q    <= ACK;
                        host_ack_o <= 1'b1;  // merged result is registered here
                    end
                end
                ACK: begin
                    if (!host_req_i) begin
                        state_q <= RELEASE;
                    end
                end
                RELEASE: begin
                    // ack drops one cycle after req was seen low
                    state_q    <= IDLE;
                    host_ack_o <= 1'b0;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

endmodule : host_cmd_fsm

// File: verilog/host_word_buffer.sv
`include "sys_master_params.svh"

module host_word_buffer
    import sys_master_pkg::*;
(
    input  logic       sys_clock_i,
    input  logic       rst_i,
    input  logic       load_i,
    input  logic       hi_sel_i,
    input  logic       host_we_i,
    input  addr_t      host_addr_i,
    input  host_data_t host_wdata_i,
    input  host_strb_t host_wstrb_i,
    output host_data_t host_rdata_o,
    output resp_t      host_resp_o,
    beat_if.data       beat
);

    localparam int DW = `AXI_DATA_W;
    localparam int SW = `AXI_DATA_W / 8;

    logic       we_q;
    addr_t      addr_q;
    host_data_t wdata_q;
    host_strb_t wstrb_q;

    // command copy, held for both beats
    always_ff @(posedge sys_clock_i) begin
        if (load_i) begin
            we_q    <= host_we_i;
            addr_q  <= host_addr_i;
            wdata_q <= host_wdata_i;
            wstrb_q <= host_wstrb_i;
        end
    end

    // bits 2:0 dropped, bit 2 picks the half
    assign beat.is_write   = we_q;
    assign beat.addr       = {addr_q[`AXI_ADDR_W-1:3], hi_sel_i, 2'b00};
    assign beat.wbeat.data = hi_sel_i ? wdata_q[DW +: DW] : wdata_q[0 +: DW];
    assign beat.wbeat.strb = hi_sel_i ? wstrb_q[SW +: SW] : wstrb_q[0 +: SW];

    // merge read halves, keep the worst response
    always_ff @(posedge sys_clock_i) begin
        if (rst_i || load_i) begin
            host_rdata_o <= '0;
            host_resp_o  <= `RESP_OKAY;
        end else if (beat.done) begin
            if (!we_q) begin
                if (hi_sel_i) begin
                    host_rdata_o[DW +: DW] <= beat.rdata;
                end else begin
                    host_rdata_o[0 +: DW] <= beat.rdata;
                end
            end
            if (beat.resp > host_resp_o) begin
                host_resp_o <= beat.resp;  // DECERR over SLVERR over OKAY
            end
        end
    end

endmodule : host_word_buffer

// File: verilog/axi_channel_slot.sv
module axi_channel_slot #(
    parameter type payload_t = logic
) (
    input  logic     sys_clock_i,
    input  logic     rst_i,
    input  logic     load_i,
    input  payload_t payload_i,
    input  logic     ready_i,
    output logic     valid_o,
    output payload_t payload_o
);

    // valid stays up until the slave takes it
    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (load_i) begin
            valid_o <= 1'b1;
        end else if (ready_i) begin
            valid_o <= 1'b0;
        end
    end

    // payload only moves on load, so it is stable under back-pressure
    always_ff @(posedge sys_clock_i) begin
        if (load_i) begin
            payload_o <= payload_i;
        end
    end

endmodule : axi_channel_slot

// File: verilog/axi_lite_beat_engine.sv
module axi_lite_beat_engine
    import sys_master_pkg::*;
(
    input  logic       sys_clock_i,
    input  logic       rst_i,
    beat_if.engine     beat,
    // write address / data / response
    output addr_t      m_axi_awaddr,
    output logic [2:0] m_axi_awprot,
    output logic       m_axi_awvalid,
    input  logic       m_axi_awready,
    output axi_data_t  m_axi_wdata,
    output axi_strb_t  m_axi_wstrb,
    output logic       m_axi_wvalid,
    input  logic       m_axi_wready,
    input  resp_t      m_axi_bresp,
    input  logic       m_axi_bvalid,
    output logic       m_axi_bready,
    // read address / data
    output addr_t      m_axi_araddr,
    output logic [2:0] m_axi_arprot,
    output logic       m_axi_arvalid,
    input  logic       m_axi_arready,
    input  axi_data_t  m_axi_rdata,
    input  resp_t      m_axi_rresp,
    input  logic       m_axi_rvalid,
    output logic       m_axi_rready
);

    logic   busy_q;   // beat accepted, done not yet given
    logic   wait_q;   // requests sent, response pending
    logic   write_q;
    logic   req_sent;
    logic   rsp_hs;
    wbeat_t w_payload;

    axi_channel_slot #(.payload_t(addr_t)) aw_slot_u (
        .sys_clock_i ( sys_clock_i                 ),
        .rst_i       ( rst_i                       ),
        .load_i      ( beat.start && beat.is_write ),
        .payload_i   ( beat.addr                   ),
        .ready_i     ( m_axi_awready               ),
        .valid_o     ( m_axi_awvalid               ),
        .payload_o   ( m_axi_awaddr                )
    );

    axi_channel_slot #(.payload_t(wbeat_t)) w_slot_u (
        .sys_clock_i ( sys_clock_i                 ),
        .rst_i       ( rst_i                       ),
        .load_i      ( beat.start && beat.is_write ),
        .payload_i   ( beat.wbeat                  ),
        .ready_i     ( m_axi_wready                ),
        .valid_o     ( m_axi_wvalid                ),
        .payload_o   ( w_payload                   )
    );

    axi_channel_slot #(.payload_t(addr_t)) ar_slot_u (
        .sys_clock_i ( sys_clock_i                  ),
        .rst_i       ( rst_i                        ),
        .load_i      ( beat.start && !beat.is_write ),
        .payload_i   ( beat.addr                    ),
        .ready_i     ( m_axi_arready                ),
        .valid_o     ( m_axi_arvalid                ),
        .payload_o   ( m_axi_araddr                 )
    );

    assign m_axi_wdata  = w_payload.data;
    assign m_axi_wstrb  = w_payload.strb;
    assign m_axi_awprot = 3'b000;  // unprivileged secure data
    assign m_axi_arprot = 3'b000;

    // no request channel still holding valid after this edge
    assign req_sent = busy_q && !wait_q
                      && !(m_axi_awvalid && !m_axi_awready)
                      && !(m_axi_wvalid && !m_axi_wready)
                      && !(m_axi_arvalid && !m_axi_arready);

    assign m_axi_bready = wait_q && write_q;
    assign m_axi_rready = wait_q && !write_q;
    assign rsp_hs       = write_q ? (m_axi_bvalid && m_axi_bready)
                                  : (m_axi_rvalid && m_axi_rready);

    // result handed over in the response handshake cycle
    assign beat.done  = rsp_hs;
    assign beat.rdata = m_axi_rdata;
    assign beat.resp  = write_q ? m_axi_bresp : m_axi_rresp;

    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            busy_q  <= 1'b0;
            wait_q  <= 1'b0;
            write_q <= 1'b0;
        end else begin
            if (beat.start) begin
                busy_q  <= 1'b1;
                write_q <= beat.is_write;
            end else if (rsp_hs) begin
                busy_q <= 1'b0;
            end
            if (req_sent) begin
                wait_q <= 1'b1;
            end else if (rsp_hs) begin
                wait_q <= 1'b0;
            end
        end
    end

endmodule : axi_lite_beat_engine

// File: verilog/sys_master.sv
`include "sys_master_params.svh"

module sys_master (
    input  logic                      sys_clock_i,
    input  logic                      rst_i,
    // host command port
    input  logic                      host_req_i,
    input  logic                      host_we_i,
    input  logic [`AXI_ADDR_W-1:0]    host_addr_i,
    input  logic [`HOST_DATA_W-1:0]   host_wdata_i,
    input  logic [`HOST_DATA_W/8-1:0] host_wstrb_i,
    output logic                      host_ack_o,
    output logic [`HOST_DATA_W-1:0]   host_rdata_o,
    output logic [1:0]                host_resp_o,
    // AXI4-Lite master
    output logic [`AXI_ADDR_W-1:0]    m_axi_awaddr,
    output logic [2:0]                m_axi_awprot,
    output logic                      m_axi_awvalid,
    input  logic                      m_axi_awready,
    output logic [`AXI_DATA_W-1:0]    m_axi_wdata,
    output logic [`AXI_DATA_W/8-1:0]  m_axi_wstrb,
    output logic                      m_axi_wvalid,
    input  logic                      m_axi_wready,
    input  logic [1:0]                m_axi_bresp,
    input  logic                      m_axi_bvalid,
    output logic                      m_axi_bready,
    output logic [`AXI_ADDR_W-1:0]    m_axi_araddr,
    output logic [2:0]                m_axi_arprot,
    output logic                      m_axi_arvalid,
    input  logic                      m_axi_arready,
    input  logic [`AXI_DATA_W-1:0]    m_axi_rdata,
    input  logic [1:0]                m_axi_rresp,
    input  logic                      m_axi_rvalid,
    output logic                      m_axi_rready,
    // reset to the SoC
    output logic                      sys_resetn_o
);

    logic load;
    logic hi_sel;

    beat_if beat_bus ();

    reset_hold_timer reset_hold_timer_u (
        .sys_clock_i  ( sys_clock_i  ),
        .rst_i        ( rst_i        ),
        .sys_resetn_o ( sys_resetn_o )
    );

    // sequencer waits for the SoC reset release
    host_cmd_fsm host_cmd_fsm_u (
        .sys_clock_i  ( sys_clock_i  ),
        .rst_i        ( rst_i        ),
        .sys_resetn_i ( sys_resetn_o ),
        .host_req_i   ( host_req_i   ),
        .host_ack_o   ( host_ack_o   ),
        .load_o       ( load         ),
        .hi_sel_o     ( hi_sel       ),
        .beat         ( beat_bus     )
    );

    host_word_buffer host_word_buffer_u (
        .sys_clock_i  ( sys_clock_i  ),
        .rst_i        ( rst_i        ),
        .load_i       ( load         ),
        .hi_sel_i     ( hi_sel       ),
        .host_we_i    ( host_we_i    ),
        .host_addr_i  ( host_addr_i  ),
        .host_wdata_i ( host_wdata_i ),
        .host_wstrb_i ( host_wstrb_i ),
        .host_rdata_o ( host_rdata_o ),
        .host_resp_o  ( host_resp_o  ),
        .beat         ( beat_bus     )
    );

    axi_lite_beat_engine axi_lite_beat_engine_u (
        .sys_clock_i   ( sys_clock_i   ),
        .rst_i         ( rst_i         ),
        .beat          ( beat_bus      ),
        .m_axi_awaddr  ( m_axi_awaddr  ),
        .m_axi_awprot  ( m_axi_awprot  ),
        .m_axi_awvalid ( m_axi_awvalid ),
        .m_axi_awready ( m_axi_awready ),
        .m_axi_wdata   ( m_axi_wdata   ),
        .m_axi_wstrb   ( m_axi_wstrb   ),
        .m_axi_wvalid  ( m_axi_wvalid  ),
        .m_axi_wready  ( m_axi_wready  ),
        .m_axi_bresp   ( m_axi_bresp   ),
        .m_axi_bvalid  ( m_axi_bvalid  ),
        .m_axi_bready  ( m_axi_bready  ),
        .m_axi_araddr  ( m_axi_araddr  ),
        .m_axi_arprot  ( m_axi_arprot  ),
        .m_axi_arvalid ( m_axi_arvalid ),
        .m_axi_arready ( m_axi_arready ),
        .m_axi_rdata   ( m_axi_rdata   ),
        .m_axi_rresp   ( m_axi_rresp   ),
        .m_axi_rvalid  ( m_axi_rvalid  ),
        .m_axi_rready  ( m_axi_rready  )
    );

endmodule : sys_master

// File: verif/sys_master_chk.sv
module sys_master_chk
    import sys_master_pkg::*;
(
    input logic      clk_i,
    input logic      rst_i,
    input logic      host_req_i,
    input logic      host_ack_i,
    input logic      awvalid_i,
    input logic      awready_i,
    input addr_t     awaddr_i,
    input logic      wvalid_i,
    input logic      wready_i,
    input axi_data_t wdata_i,
    input axi_strb_t wstrb_i,
    input logic      arvalid_i,
    input logic      arready_i,
    input addr_t     araddr_i,
    input logic      bready_i,
    input logic      rready_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int fails = 0;  // failed assertions so far

    // ack holds as long as the host keeps req up
    ack_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        host_ack_i && host_req_i |=> host_ack_i)
        else begin
            fails++;
            $error("host_ack_o fell while host_req_i was still high");
        end

    aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
        else begin
            fails++;
            $error("awvalid dropped or awaddr changed before awready");
        end

    w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
        else begin
            fails++;
            $error("wvalid dropped or W payload changed before wready");
        end

    ar_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
        else begin
            fails++;
            $error("arvalid dropped or araddr changed before arready");
        end

    // one beat in flight, response phase never overlaps a request
    one_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
        !(bready_i && rready_i)
        && !((bready_i || rready_i) && (awvalid_i || wvalid_i || arvalid_i)))
        else begin
            fails++;
            $error("response ready high with the other ready or a request valid");
        end

endmodule : sys_master_chk

// File: verif/sys_master_tb.sv
`include "sys_master_params.svh"

module sys_master_tb
    import sys_master_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int    WAIT_LIMIT  = 200;
    localparam addr_t SLV_LO      = 32'h0000_0304;  // SLVERR window, both ends included
    localparam addr_t SLV_HI      = 32'h0000_033B;
    localparam addr_t DECERR_BASE = 32'h0000_03FC;  // DECERR from here up

    typedef enum {W_VALID, B_READY, R_READY, HOST_ACK} watch_t;

    typedef struct packed {
        logic       we;
        addr_t      addr;
        resp_t      resp;
        host_data_t data;
    } result_t;

    logic       sys_clock_i, rst_i, sys_resetn_o;
    logic       host_req_i, host_we_i, host_ack_o;
    addr_t      host_addr_i;
    host_data_t host_wdata_i, host_rdata_o;
    host_strb_t host_wstrb_i;
    resp_t      host_resp_o, m_axi_bresp, m_axi_rresp;
    addr_t      m_axi_awaddr, m_axi_araddr;
    logic [2:0] m_axi_awprot, m_axi_arprot;
    axi_data_t  m_axi_wdata, m_axi_rdata;
    axi_strb_t  m_axi_wstrb;
    logic       m_axi_awvalid, m_axi_awready, m_axi_wvalid, m_axi_wready;
    logic       m_axi_bvalid, m_axi_bready, m_axi_arvalid, m_axi_arready;
    logic       m_axi_rvalid, m_axi_rready;

    axi_data_t mem [256];     // slave model storage
    axi_data_t shadow [256];  // reference copy
    result_t   exp_q [$];
    result_t   act_q [$];
    int        errors = 0;
    int        timeouts = 0;
    int        checks = 0;
    logic      ack_prev = 1'b0;
    logic      req_prev = 1'b0;

    sys_master dut0 (.*);

    bind sys_master sys_master_chk chk0 (
        .clk_i      ( sys_clock_i   ),
        .rst_i      ( rst_i         ),
        .host_req_i ( host_req_i    ),
        .host_ack_i ( host_ack_o    ),
        .awvalid_i  ( m_axi_awvalid ),
        .awready_i  ( m_axi_awready ),
        .awaddr_i   ( m_axi_awaddr  ),
        .wvalid_i   ( m_axi_wvalid  ),
        .wready_i   ( m_axi_wready  ),
        .wdata_i    ( m_axi_wdata   ),
        .wstrb_i    ( m_axi_wstrb   ),
        .arvalid_i  ( m_axi_arvalid ),
        .arready_i  ( m_axi_arready ),
        .araddr_i   ( m_axi_araddr  ),
        .bready_i   ( m_axi_bready  ),
        .rready_i   ( m_axi_rready  )
    );

    initial begin
        sys_clock_i = 1'b0;
        forever #50 sys_clock_i = ~sys_clock_i;
    end

    task automatic next_cycle();
        @(posedge sys_clock_i);
        #10;  // drive point, DUT outputs settled
    endtask

    task automatic idle_cycles(input int unsigned count);
        repeat (count) next_cycle();
    endtask

    function automatic logic level_of(input watch_t sig);
        case (sig)
            W_VALID: return m_axi_wvalid;
            B_READY: return m_axi_bready;
            R_READY: return m_axi_rready;
            default: return host_ack_o;
        endcase
    endfunction

    task automatic wait_level(input watch_t sig, input logic level, input string what);
        int n;
        n = 0;
        while (level_of(sig) !== level && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (level_of(sig) !== level) begin
            timeouts++;
            $display("timeout: %s did not go %0b within %0d cycles", what, level, WAIT_LIMIT);
        end
    endtask

    function automatic axi_data_t fill_word(input logic [7:0] idx);
        return {16'hC0DE, 6'h00, idx, 2'b00};
    endfunction

    // address map of the slave model
    function automatic resp_t beat_resp(input addr_t a);
        if (a >= DECERR_BASE) return `RESP_DECERR;
        if (a >= SLV_LO && a <= SLV_HI) return `RESP_SLVERR;
        return `RESP_OKAY;
    endfunction

    // expected result of one host command, updates the shadow on writes
    function automatic void predict(input logic we, input addr_t addr, input host_data_t wdata,
                                    input host_strb_t wstrb, output result_t exp);
        addr_t ba;
        resp_t r;
        exp = '{we: we, addr: addr, resp: `RESP_OKAY, data: '0};
        for (int h = 0; h < 2; h++) begin
            ba = {addr[31:3], 3'b000} + addr_t'(4 * h);  // low word first
            r  = beat_resp(ba);
            if (r > exp.resp) exp.resp = r;
            if (r == `RESP_OKAY && we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[4*h+b]) shadow[ba[9:2]][8*b +: 8] = wdata[32*h+8*b +: 8];
                end
            end else if (r == `RESP_OKAY) begin
                exp.data[32*h +: 32] = shadow[ba[9:2]];
            end
        end
    endfunction

    task automatic run_cmd(input logic we, input addr_t addr, input host_data_t wdata,
                           input host_strb_t wstrb);
        result_t exp;
        result_t act;
        predict(we, addr, wdata, wstrb, exp);
        exp_q.push_back(exp);
        host_we_i    = we;
        host_addr_i  = addr;
        host_wdata_i = wdata;
        host_wstrb_i = wstrb;
        host_req_i   = 1'b1;
        wait_level(HOST_ACK, 1'b1, "host_ack_o");
        act = '{we: we, addr: addr, resp: host_resp_o, data: host_rdata_o};
        act_q.push_back(act);
        host_req_i = 1'b0;
        wait_level(HOST_ACK, 1'b0, "host_ack_o");
    endtask

    // AXI4-Lite slave, one beat at a time, random ready delays
    initial begin : slave_model
        addr_t     addr;
        axi_data_t wdata;
        axi_strb_t wstrb;
        resp_t     resp;
        forever begin
            next_cycle();
            if (m_axi_awvalid) begin
                addr = m_axi_awaddr;
                assert (m_axi_awprot == 3'b000) else begin
                    errors++;
                    $display("[FAIL] %0d ns: awprot %b, expected 000", $time, m_axi_awprot);
                end
                idle_cycles($urandom_range(0, 3));
                m_axi_awready = 1'b1;
                next_cycle();
                m_axi_awready = 1'b0;
                wait_level(W_VALID, 1'b1, "m_axi_wvalid");
                wdata = m_axi_wdata;
                wstrb = m_axi_wstrb;
                idle_cycles($urandom_range(0, 3));
                m_axi_wready = 1'b1;
                next_cycle();
                m_axi_wready = 1'b0;
                resp = beat_resp(addr);
                for (int b = 0; b < 4; b++) begin
                    if (resp == `RESP_OKAY && wstrb[b]) mem[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
                end
                idle_cycles($urandom_range(0, 3));
                m_axi_bresp  = resp;
                m_axi_bvalid = 1'b1;
                wait_level(B_READY, 1'b1, "m_axi_bready");
                next_cycle();
                m_axi_bvalid = 1'b0;
            end else if (m_axi_arvalid) begin
                addr = m_axi_araddr;
                assert (m_axi_arprot == 3'b000) else begin
                    errors++;
                    $display("[FAIL] %0d ns: arprot %b, expected 000", $time, m_axi_arprot);
                end
                idle_cycles($urandom_range(0, 3));
                m_axi_arready = 1'b1;
                next_cycle();
                m_axi_arready = 1'b0;
                idle_cycles($urandom_range(0, 3));
                resp         = beat_resp(addr);
                m_axi_rresp  = resp;
                m_axi_rdata  = (resp == `RESP_OKAY) ? mem[addr[9:2]] : '0;  // zero on error
                m_axi_rvalid = 1'b1;
                wait_level(R_READY, 1'b1, "m_axi_rready");
                next_cycle();
                m_axi_rvalid = 1'b0;
            end
        end
    end

    always @(posedge sys_clock_i) begin : compare_results
        result_t    exp;
        result_t    act;
        logic [7:0] lo;
        if (act_q.size() != 0) begin
            act = act_q.pop_front();
            exp = exp_q.pop_front();
            lo  = {act.addr[9:3], 1'b0};
            checks++;
            assert (act.resp == exp.resp) else begin
                errors++;
                $display("[FAIL] %0d ns: addr %h resp %0d, expected %0d",
                         $time, act.addr, act.resp, exp.resp);
            end
            if (!exp.we) begin
                assert (act.data == exp.data) else begin
                    errors++;
                    $display("[FAIL] %0d ns: read %h gave %h, expected %h",
                             $time, act.addr, act.data, exp.data);
                end
            end else if ({act.addr[31:3], 3'b000} < DECERR_BASE) begin
                assert (mem[lo] == shadow[lo] && mem[lo+1] == shadow[lo+1]) else begin
                    errors++;
                    $display("[FAIL] %0d ns: write %h left memory %h_%h, expected %h_%h",
                             $time, act.addr, mem[lo+1], mem[lo], shadow[lo+1], shadow[lo]);
                end
            end
        end
    end

    // four-phase order, values seen before each edge
    always @(posedge sys_clock_i) begin : handshake_monitor
        if (!rst_i) begin
            if (host_ack_o && !ack_prev) begin
                assert (req_prev) else begin
                    errors++;
                    $display("[FAIL] %0d ns: host_ack_o rose without host_req_i", $time);
                end
            end
            if (!host_ack_o && ack_prev) begin
                assert (!req_prev) else begin
                    errors++;
                    $display("[FAIL] %0d ns: host_ack_o fell while host_req_i high", $time);
                end
            end
            assert (!(host_ack_o && (m_axi_awvalid || m_axi_wvalid || m_axi_arvalid))) else begin
                errors++;
                $display("[FAIL] %0d ns: AXI valid high while host_ack_o high", $time);
            end
        end
        ack_prev <= host_ack_o;
        req_prev <= host_req_i;
    end

    initial begin : main
        int    n;
        int    slot;
        addr_t addr;
        void'($urandom(35355));
        rst_i         = 1'b1;
        host_req_i    = 1'b0;
        host_we_i     = 1'b0;
        host_addr_i   = '0;
        host_wdata_i  = '0;
        host_wstrb_i  = '0;
        m_axi_awready = 1'b0;
        m_axi_wready  = 1'b0;
        m_axi_bvalid  = 1'b0;
        m_axi_bresp   = `RESP_OKAY;
        m_axi_arready = 1'b0;
        m_axi_rvalid  = 1'b0;
        m_axi_rresp   = `RESP_OKAY;
        m_axi_rdata   = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i]    = fill_word(8'(i));
            shadow[i] = fill_word(8'(i));
        end
        repeat (10) begin
            next_cycle();
            assert (sys_resetn_o === 1'b0) else begin
                errors++;
                $display("[FAIL] %0d ns: sys_resetn_o high during rst_i", $time);
            end
        end
        host_req_i = 1'b1;  // early read of address 0, must wait for the release
        rst_i      = 1'b0;
        n = 0;
        while (sys_resetn_o !== 1'b1 && n < WAIT_LIMIT) begin
            assert (!host_ack_o && !m_axi_awvalid && !m_axi_wvalid && !m_axi_arvalid) else begin
                errors++;
                $display("[FAIL] %0d ns: host_ack_o or an AXI valid high in reset hold", $time);
            end
            next_cycle();
            n++;
        end
        assert (n == `RESET_HOLD_CYCLES) else begin
            errors++;
            $display("[FAIL] %0d ns: sys_resetn_o rose after %0d cycles, expected %0d",
                     $time, n, `RESET_HOLD_CYCLES);
        end
        run_cmd(1'b0, 32'h0000_0000, '0, '0);
        run_cmd(1'b1, 32'h0000_0040, 64'h0123_4567_89AB_CDEF, 8'hFF);
        run_cmd(1'b0, 32'h0000_0045, '0, '0);          // low bits ignored
        run_cmd(1'b1, 32'h0000_0300, 64'hFFFF_0000_1234_5678, 8'hFF);  // high beat SLVERR
        run_cmd(1'b0, 32'h0000_0300, '0, '0);
        run_cmd(1'b0, 32'h0000_0338, '0, '0);          // low beat SLVERR
        run_cmd(1'b1, 32'h0000_03F8, 64'hAAAA_BBBB_CCCC_DDDD, 8'hF0);  // high beat DECERR
        run_cmd(1'b0, 32'h0000_03F8, '0, '0);
        run_cmd(1'b0, 32'h8000_0000, '0, '0);
        repeat (100) begin
            slot = ($urandom_range(0, 3) == 0) ? $urandom_range(0, 127) : $urandom_range(0, 15);
            addr = (addr_t'(slot) << 3) | addr_t'($urandom_range(0, 7));
            run_cmd(1'($urandom_range(0, 1)), addr, {$urandom, $urandom}, 8'($urandom));
        end
        n = 0;
        while (act_q.size() != 0 && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (act_q.size() != 0 || exp_q.size() != 0) begin
            errors++;
            $display("some commands were never compared against the reference");
        end
        errors += dut0.chk0.fails;  // failed checker assertions
        $display("%0d commands checked, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : sys_master_tb

// File: sys_master.f
+incdir+verilog
verilog/sys_master_pkg.sv
verilog/beat_if.sv
verilog/reset_hold_timer.sv
verilog/host_cmd_fsm.sv
verilog/host_word_buffer.sv
verilog/axi_channel_slot.sv
verilog/axi_lite_beat_engine.sv
verilog/sys_master.sv
verif/sys_master_chk.sv
verif/sys_master_tb.sv

// File: Makefile
# Verilator build and run for the sys_master testbench

VERILATOR ?= verilator
TOP       ?= sys_master_tb
FLIST     ?= sys_master.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
PASS_TEXT ?= TESTS PASSED

SRCS := $(wildcard verilog/*.sv verilog/*.svh verif/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status comes from the search for the pass line
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
